// File: all.f
source/regview_pkg.sv
source/scan_pos_if.sv
source/glyph_pix_if.sv
source/char_scanner.sv
source/glyph_rom.sv
source/char_select.sv
source/pixel_plotter.sv
source/register_viewer.sv
testbench/plot_checker.sv
testbench/tb_register_viewer.sv

// File: testbench/tb_register_viewer.sv
// Register viewer testbench
// Applies a table of register banks, one per frame, and reports the checker results
`timescale 1ns/1ps
`default_nettype none

module tb_register_viewer;

	localparam int NUM_TESTS   = 6;
	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 1;    // Inputs change just after the rising edge
	localparam int WATCHDOG_NS = (NUM_TESTS + 1) * regview_pkg::PIXELS_PER_FRAME * CLK_PERIOD
		+ 50 * CLK_PERIOD;

	logic                   clock;
	logic                   resetn;
	regview_pkg::reg_bank_t reg_bank;
	logic [127:0]           test_name;
	regview_pkg::coord_x_t  plot_x;
	regview_pkg::coord_y_t  plot_y;
	regview_pkg::color_t    plot_color;
	logic                   plot;
	int                     frames_done;
	int                     pass_count;
	int                     fail_count;
	int                     other_errors;

	regview_pkg::reg_bank_t bank_table [NUM_TESTS];
	logic [127:0]           name_table [NUM_TESTS];

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fill_table();
		logic [31:0] rng;
		logic [31:0] word;
		rng = 32'h70d1_8508;
		for (int r = 0; r < regview_pkg::NUM_ROWS; r++) begin
			for (int n = 0; n < 8; n++)
				word[31 - 4 * n -: 4] = 4'(r * 8 + n);   // 01234567, 89abcdef, ...
			bank_table[0][r] = '0;
			bank_table[1][r] = '1;
			bank_table[2][r] = word;
		end
		bank_table[3] = {32'h7ffffffe, 32'h80000001, 32'h4b5a6978, 32'h0f1e2d3c,
			32'h9abcdef0, 32'h12345678, 32'hcafef00d, 32'hdeadbeef};
		for (int b = 4; b < NUM_TESTS; b++) begin
			for (int r = 0; r < regview_pkg::NUM_ROWS; r++) begin
				rng = xorshift32(rng);
				bank_table[b][r] = rng;
			end
		end
		name_table[0] = "all zeros";
		name_table[1] = "all ones";
		name_table[2] = "counting nibbles";
		name_table[3] = "one reg per row";
		name_table[4] = "xorshift bank 1";
		name_table[5] = "xorshift bank 2";
	endtask

	always #(CLK_PERIOD / 2) clock = ~clock;

	register_viewer dut (
		.clock      (clock),
		.resetn     (resetn),
		.reg_bank   (reg_bank),
		.plot_x     (plot_x),
		.plot_y     (plot_y),
		.plot_color (plot_color),
		.plot       (plot)
	);

	plot_checker u_checker (
		.clock        (clock),
		.resetn       (resetn),
		.reg_bank     (reg_bank),
		.test_name    (test_name),
		.plot_x       (plot_x),
		.plot_y       (plot_y),
		.plot_color   (plot_color),
		.plot         (plot),
		.frames_done  (frames_done),
		.pass_count   (pass_count),
		.fail_count   (fail_count),
		.other_errors (other_errors)
	);

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: only %0d of %0d frames were checked within %0d ns",
			frames_done, NUM_TESTS, WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		clock     = 1'b0;
		resetn    = 1'b0;
		reg_bank  = '0;
		test_name = '0;
		fill_table();
		repeat (2) @(posedge clock);
		#(DRIVE_DELAY);
		resetn    = 1'b1;
		reg_bank  = bank_table[0];
		test_name = name_table[0];
		@(posedge clock);   // Scanner frame 0 starts here
		for (int t = 1; t < NUM_TESTS; t++) begin
			repeat (regview_pkg::PIXELS_PER_FRAME) @(posedge clock);
			#(DRIVE_DELAY);
			reg_bank  = bank_table[t];
			test_name = name_table[t];
		end
		wait (frames_done == NUM_TESTS);
		$display("Results: %0d tests passed, %0d failed, %0d other errors",
			pass_count, fail_count, other_errors);
		if (pass_count == NUM_TESTS && fail_count == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/plot_checker.sv
// Plot checker
// Rebuilds each register line as text and compares every plotted pixel with it
`timescale 1ns/1ps
`default_nettype none

module plot_checker (
	input  logic                   clock,
	input  logic                   resetn,
	input  regview_pkg::reg_bank_t reg_bank,
	input  logic [127:0]           test_name,
	input  regview_pkg::coord_x_t  plot_x,
	input  regview_pkg::coord_y_t  plot_y,
	input  regview_pkg::color_t    plot_color,
	input  logic                   plot,
	output int                     frames_done,
	output int                     pass_count,
	output int                     fail_count,
	output int                     other_errors
);

	regview_pkg::reg_bank_t bank_d1;
	regview_pkg::reg_bank_t bank_d2;   // Bank the DUT used for this pixel
	logic [127:0]           name_d1;
	logic [127:0]           name_d2;
	int                     clocks_since_release;
	int                     px;
	int                     py;
	int                     col;
	int                     row;
	int                     frame_errors;

	// Rows listed top first, bit 7 leftmost
	function automatic logic [63:0] font_rows(input logic [7:0] ch);
		case (ch)
			"0": font_rows = 64'h007C868A92A2C27C;
			"1": font_rows = 64'h00705010101010FE;
			"2": font_rows = 64'h007884040810207C;
			"3": font_rows = 64'h00FC02023C0202FC;
			"4": font_rows = 64'h00888888FE080808;
			"5": font_rows = 64'h00FE8080FC0202FC;
			"6": font_rows = 64'h007C8080FC82827C;
			"7": font_rows = 64'h00FE020408102040;
			"8": font_rows = 64'h007C82827C82827C;
			"9": font_rows = 64'h007C82827E020202;
			"a": font_rows = 64'h00788484FC848484;
			"b": font_rows = 64'h00F88484F88484F8;
			"c": font_rows = 64'h007C82808080827C;
			"d": font_rows = 64'h00F08884848488F0;
			"e": font_rows = 64'h00FC8080FC8080FC;
			"f": font_rows = 64'h00FC8080FC808080;
			"R": font_rows = 64'h00F88484F8908884;
			":": font_rows = 64'h0060600000606000;
			default: font_rows = '0;   // Space
		endcase
	endfunction

	function automatic logic pixel_bit(input regview_pkg::reg_word_t word,
		input int r, input int c, input int x, input int y);
		string       line;
		logic [63:0] rows;
		line = $sformatf("R%0d: %h", r, word);   // e.g. R3: 0badf00d
		rows = font_rows(line[c]);
		pixel_bit = rows[63 - 8 * y - x];
	endfunction

	task automatic check_value(input string what, input int exp_v, input int act_v);
		if (exp_v != act_v) begin
			frame_errors++;
			$display("[ERROR] %0s: %0s row %0d col %0d px %0d py %0d expected %0d actual %0d",
				name_d2, what, row, col, px, py, exp_v, act_v);
		end
	endtask

	task automatic finish_frame();
		if (frame_errors == 0) begin
			pass_count++;
			$display("[PASS] %0s: %0d pixels match", name_d2, regview_pkg::PIXELS_PER_FRAME);
		end else begin
			fail_count++;
			$display("[FAIL] %0s: %0d mismatches", name_d2, frame_errors);
		end
		frame_errors = 0;
		frames_done++;
	endtask

	always @(posedge clock or negedge resetn) begin
		if (!resetn)
			clocks_since_release <= 0;
		else
			clocks_since_release <= clocks_since_release + 1;
	end

	// Outputs settle between edges, so compare on the falling edge
	always @(negedge clock) begin
		if (!resetn) begin
			frames_done  = 0;
			pass_count   = 0;
			fail_count   = 0;
			other_errors = 0;
			frame_errors = 0;
			px = 0;
			py = 0;
			col = 0;
			row = 0;
			if (plot !== 1'b0) begin
				$display("plot strobe is high while reset is asserted");
				other_errors++;
			end
		end else if (clocks_since_release < 3) begin   // Two-stage pipeline still filling
			if (plot !== 1'b0) begin
				$display("plot strobe rose too early, %0d clocks after reset release",
					clocks_since_release);
				other_errors++;
			end
		end else begin
			if (plot !== 1'b1) begin
				$display("plot strobe is low %0d clocks after reset release",
					clocks_since_release);
				other_errors++;
			end
			check_value("plot_x", regview_pkg::ORIGIN_X + col * regview_pkg::CHAR_PITCH_X + px,
				int'(plot_x));
			check_value("plot_y", regview_pkg::ORIGIN_Y + row * regview_pkg::ROW_PITCH_Y + py,
				int'(plot_y));
			check_value("plot_color", pixel_bit(bank_d2[row], row, col, px, py) ?
				regview_pkg::COLOR_ON : regview_pkg::COLOR_OFF, int'(plot_color));
			px++;
			if (px == regview_pkg::CHAR_SIZE) begin
				px = 0;
				py++;
				if (py == regview_pkg::CHAR_SIZE) begin
					py = 0;
					col++;
					if (col == regview_pkg::NUM_COLS) begin
						col = 0;
						row++;
						if (row == regview_pkg::NUM_ROWS) begin
							row = 0;
							finish_frame();
						end
					end
				end
			end
		end
		bank_d2 = bank_d1;
		bank_d1 = reg_bank;
		name_d2 = name_d1;
		name_d1 = test_name;
	end

endmodule

`default_nettype wire

// File: source/register_viewer.sv
// Register viewer top level
// Scanner, character selector and plotter, two clocks from position to pixel
`timescale 1ns/1ps
`default_nettype none

module register_viewer (
	input  logic                   clock,
	input  logic                   resetn,
	input  regview_pkg::reg_bank_t reg_bank,
	output regview_pkg::coord_x_t  plot_x,
	output regview_pkg::coord_y_t  plot_y,
	output regview_pkg::color_t    plot_color,
	output logic                   plot
);

	scan_pos_if  pos_bus ();
	glyph_pix_if pix_bus ();

	char_scanner u_scanner (
		.clock  (clock),
		.resetn (resetn),
		.pos    (pos_bus.scanner)
	);

	char_select u_select (
		.clock    (clock),
		.resetn   (resetn),
		.reg_bank (reg_bank),
		.pos      (pos_bus.selector),
		.pix      (pix_bus.selector)
	);

	pixel_plotter u_plotter (
		.clock      (clock),
		.resetn     (resetn),
		.pix        (pix_bus.plotter),
		.plot_x     (plot_x),
		.plot_y     (plot_y),
		.plot_color (plot_color),
		.plot       (plot)
	);

endmodule

`default_nettype wire

// File: source/pixel_plotter.sv
// Pixel plotter
// Turns a glyph bit and its grid position into a screen coordinate and colour
`timescale 1ns/1ps
`default_nettype none

module pixel_plotter (
	input  logic                  clock,
	input  logic                  resetn,
	glyph_pix_if.plotter          pix,
	output regview_pkg::coord_x_t plot_x,
	output regview_pkg::coord_y_t plot_y,
	output regview_pkg::color_t   plot_color,
	output logic                  plot
);

	localparam regview_pkg::coord_x_t X_LAST = regview_pkg::ORIGIN_X
		+ 10'((regview_pkg::NUM_COLS - 1) * regview_pkg::CHAR_PITCH_X)
		+ 10'(regview_pkg::CHAR_SIZE - 1);   // Right edge of column 11

	regview_pkg::coord_x_t x_next;
	regview_pkg::coord_y_t y_next;

	assign x_next = regview_pkg::ORIGIN_X
		+ 10'(pix.col_idx) * 10'(regview_pkg::CHAR_PITCH_X)
		+ 10'(pix.pixel_x);
	assign y_next = regview_pkg::ORIGIN_Y
		+ 9'(pix.row_idx) * 9'(regview_pkg::ROW_PITCH_Y)
		+ 9'(pix.pixel_y);

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			plot <= 1'b0;
		end else begin
			plot <= pix.valid;
		end
	end

	always_ff @(posedge clock) begin
		plot_x     <= x_next;
		plot_y     <= y_next;
		plot_color <= pix.pixel_on ? regview_pkg::COLOR_ON : regview_pkg::COLOR_OFF;
	end

	a_x_span: assert property (@(posedge clock) disable iff (!resetn)
		plot |-> (plot_x >= regview_pkg::ORIGIN_X && plot_x <= X_LAST));

endmodule

`default_nettype wire

// File: source/char_select.sv
// Character selector
// Picks each cell's code from the register bank and registers the glyph bit
`timescale 1ns/1ps
`default_nettype none

module char_select (
	input  logic                   clock,
	input  logic                   resetn,
	input  regview_pkg::reg_bank_t reg_bank,
	scan_pos_if.selector           pos,
	glyph_pix_if.selector          pix
);

	regview_pkg::reg_word_t  cur_reg;
	regview_pkg::char_code_t code;
	regview_pkg::glyph_t     glyph;
	logic [2:0]              nib_sel;    // 7 for column 4, 0 for column 11
	logic [3:0]              nibble;
	logic                    bit_on;

	assign cur_reg = reg_bank[pos.row_idx];
	assign nib_sel = 3'(4'd11 - pos.col_idx);
	assign nibble  = cur_reg[{nib_sel, 2'b00} +: 4];

	always_comb begin
		case (pos.col_idx)
			4'd0:    code = regview_pkg::CODE_R;
			4'd1:    code = {3'b000, pos.row_idx};   // Row digit
			4'd2:    code = regview_pkg::CODE_COLON;
			4'd3:    code = regview_pkg::CODE_SPACE;
			default: code = {2'b00, nibble};         // MS nibble first
		endcase
	end

	glyph_rom u_rom (
		.code  (code),
		.glyph (glyph)
	);

	// Index is y*8 + (7 - x), and 7 - x is ~x in three bits
	assign bit_on = glyph[{pos.pixel_y, ~pos.pixel_x}];

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			pix.valid <= 1'b0;
		end else begin
			pix.valid <= pos.valid;
		end
	end

	always_ff @(posedge clock) begin
		pix.row_idx  <= pos.row_idx;
		pix.col_idx  <= pos.col_idx;
		pix.pixel_x  <= pos.pixel_x;
		pix.pixel_y  <= pos.pixel_y;
		pix.pixel_on <= bit_on;
	end

	a_code_range: assert property (@(posedge clock) disable iff (!resetn)
		pos.valid |-> code <= regview_pkg::CODE_SPACE);

endmodule

`default_nettype wire

// File: source/glyph_rom.sv
// Font table
// 8x8 glyphs for hex digits, R, colon and space
`timescale 1ns/1ps
`default_nettype none

module glyph_rom (
	input  regview_pkg::char_code_t code,
	output regview_pkg::glyph_t     glyph
);

	// Each constant reads row 7 first, row 0 last
	always_comb begin
		case (code)
			6'd0:  glyph = 64'h7CC2A2928A867C00;
			6'd1:  glyph = 64'hFE10101010507000;
			6'd2:  glyph = 64'h7C20100804847800;
			6'd3:  glyph = 64'hFC02023C0202FC00;
			6'd4:  glyph = 64'h080808FE88888800;
			6'd5:  glyph = 64'hFC0202FC8080FE00;
			6'd6:  glyph = 64'h7C8282FC80807C00;
			6'd7:  glyph = 64'h402010080402FE00;
			6'd8:  glyph = 64'h7C82827C82827C00;
			6'd9:  glyph = 64'h0202027E82827C00;
			6'd10: glyph = 64'h848484FC84847800;   // A
			6'd11: glyph = 64'hF88484F88484F800;   // B
			6'd12: glyph = 64'h7C82808080827C00;   // C
			6'd13: glyph = 64'hF08884848488F000;   // D
			6'd14: glyph = 64'hFC8080FC8080FC00;   // E
			6'd15: glyph = 64'h808080FC8080FC00;   // F
			regview_pkg::CODE_R:     glyph = 64'h848890F88484F800;
			regview_pkg::CODE_COLON: glyph = 64'h0060600000606000;
			regview_pkg::CODE_SPACE: glyph = '0;
			default:                 glyph = '0;   // Unused codes draw blank
		endcase
	end

endmodule

`default_nettype wire

// File: source/char_scanner.sv
// Grid scanner
// Sweeps pixel, glyph row, column and register row, one pixel per clock
`timescale 1ns/1ps
`default_nettype none

module char_scanner (
	input  logic        clock,
	input  logic        resetn,
	scan_pos_if.scanner pos
);

	logic last_px;
	logic last_py;
	logic last_col;

	assign last_px  = (pos.pixel_x == 3'(regview_pkg::CHAR_SIZE - 1));
	assign last_py  = (pos.pixel_y == 3'(regview_pkg::CHAR_SIZE - 1));
	assign last_col = (pos.col_idx == 4'(regview_pkg::NUM_COLS - 1));

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			pos.pixel_x <= '0;
			pos.pixel_y <= '0;
			pos.col_idx <= '0;
			pos.row_idx <= '0;
			pos.valid   <= 1'b0;
		end else begin
			pos.valid <= 1'b1;
			if (pos.valid) begin   // Hold at origin for the first valid cycle
				pos.pixel_x <= pos.pixel_x + 3'd1;   // Wraps 7 -> 0 on its own
				if (last_px) begin
					pos.pixel_y <= pos.pixel_y + 3'd1;
					if (last_py) begin
						if (last_col) begin
							pos.col_idx <= '0;
							pos.row_idx <= pos.row_idx + 3'd1;   // Row 7 wraps to 0
						end else begin
							pos.col_idx <= pos.col_idx + 4'd1;
						end
					end
				end
			end
		end
	end

	// Column counter must wrap at 11, never reach the unused codes
	a_col_range: assert property (@(posedge clock) disable iff (!resetn)
		pos.col_idx <= 4'(regview_pkg::NUM_COLS - 1));

endmodule

`default_nettype wire

// File: source/glyph_pix_if.sv
// Glyph pixel bus
// One looked-up glyph bit with the position it belongs to
`timescale 1ns/1ps
`default_nettype none

interface glyph_pix_if;

	regview_pkg::row_idx_t row_idx;
	regview_pkg::col_idx_t col_idx;
	regview_pkg::pix_idx_t pixel_x;
	regview_pkg::pix_idx_t pixel_y;
	logic                  pixel_on;   // Glyph bit at this pixel
	logic                  valid;

	modport selector (output row_idx, col_idx, pixel_x, pixel_y, pixel_on, valid);
	modport plotter (input row_idx, col_idx, pixel_x, pixel_y, pixel_on, valid);

endinterface

`default_nettype wire

// File: source/scan_pos_if.sv
// Scan position bus
// Grid cell and pixel position produced by the scanner
`timescale 1ns/1ps
`default_nettype none

interface scan_pos_if;

	regview_pkg::row_idx_t row_idx;
	regview_pkg::col_idx_t col_idx;
	regview_pkg::pix_idx_t pixel_x;
	regview_pkg::pix_idx_t pixel_y;
	logic                  valid;   // Level, high every cycle once running

	modport scanner (output row_idx, col_idx, pixel_x, pixel_y, valid);
	modport selector (input row_idx, col_idx, pixel_x, pixel_y, valid);

endinterface

`default_nettype wire

// File: source/regview_pkg.sv
// Register viewer shared definitions
// Grid geometry, character codes and the vector types used across the design
`default_nettype none

package regview_pkg;

	localparam int NUM_ROWS         = 8;    // One row per register
	localparam int NUM_COLS         = 12;   // R, digit, colon, space, 8 nibbles
	localparam int CHAR_SIZE        = 8;    // Glyph width and height
	localparam int CHAR_PITCH_X     = 9;    // One blank pixel between glyphs
	localparam int ROW_PITCH_Y      = 15;
	localparam int PIXELS_PER_FRAME = NUM_ROWS * NUM_COLS * CHAR_SIZE * CHAR_SIZE;

	typedef logic [31:0]                   reg_word_t;
	typedef reg_word_t [NUM_ROWS-1:0]      reg_bank_t;
	typedef logic [2:0]                    row_idx_t;
	typedef logic [3:0]                    col_idx_t;
	typedef logic [2:0]                    pix_idx_t;
	typedef logic [5:0]                    char_code_t;
	typedef logic [63:0]                   glyph_t;    // Row 0 in low byte, bit 7 leftmost
	typedef logic [9:0]                    coord_x_t;
	typedef logic [8:0]                    coord_y_t;
	typedef logic [8:0]                    color_t;    // 3 bits per channel

	localparam coord_x_t ORIGIN_X = 10'd10;
	localparam coord_y_t ORIGIN_Y = 9'd25;

	localparam color_t COLOR_ON  = 9'h1ff;   // White
	localparam color_t COLOR_OFF = 9'h000;

	// Codes 0 to 15 are the hex digits themselves
	localparam char_code_t CODE_R     = 6'd27;
	localparam char_code_t CODE_COLON = 6'd36;
	localparam char_code_t CODE_SPACE = 6'd37;

endpackage

`default_nettype wire
